/* design/busCheck_defines.svh */
//****************************************
// widths, field positions and protocol constants of the
// CANopen request/response checker
// message layout is the 76-bit COB-ID + 8 payload bytes word
//****************************************
`ifndef BUSCHECK_DEFINES_SVH
`define BUSCHECK_DEFINES_SVH

`define MSG_W            76
`define COB_MSB          75    // COB-ID is 75:64
`define COB_LSB          64
`define FUNC_W           4     // function code is the top nibble of the COB-ID

// payload fields
`define CMD_MSB          63
`define CMD_LSB          56
`define IDX_MSB          55
`define IDX_LSB          40
`define SUB_MSB          39
`define SUB_LSB          32
`define DATA_LSB         0
`define ECHO_LSB         (`DATA_LSB + 8)   // first bit above the low data byte
`define BUSID_MSB        31
`define BUSID_LSB        24

// function codes
`define FUNC_SDO_REQ     4'h6
`define FUNC_SDO_RESP    4'h5
`define FUNC_NMT_GUARD   4'h7

// command and status bytes
`define SDO_UPLOAD_REQ   8'h40
`define SDO_UPLOAD_RESP  8'h43
`define GUARD_STATUS_OK  8'h05

`define TRIM_PATTERN     76'h555AAAAAAAAAAAAAAAA
`define TALLY_W          16

`endif

/* design/busCheckPkg.sv */
//****************************************
// types shared by the checker blocks
// widths come from the defines header
//****************************************
`include "busCheck_defines.svh"

package busCheckPkg;

  // one whole bus message, COB-ID on top
  typedef logic [`MSG_W-1:0] canMsg_t;

  typedef logic [`COB_MSB-`COB_LSB:0] cobId_t;
  typedef logic [`FUNC_W-1:0] funcCode_t;
  typedef logic [7:0] nodeId_t;                      // low byte of the COB-ID
  typedef logic [`IDX_MSB-`IDX_LSB:0] sdoIndex_t;
  typedef logic [`BUSID_MSB-`BUSID_LSB:0] busId_t;
  typedef logic [`TALLY_W-1:0] tally_t;

  // where the held request was taken from
  typedef enum logic [1:0]
  {
    originUplink,
    originDownlink,
    originTrim
  } reqOrigin_t;

  // which rule judges a pair
  typedef enum logic [1:0]
  {
    kindNodeGuard,
    kindSdoRead,
    kindTrim,
    kindEcho
  } checkKind_t;

endpackage

/* design/msgPairIf.sv */
//****************************************
// one captured request/response pair
// pairValid is a single-cycle pulse, no back-pressure
//****************************************
`timescale 1ns/1ps
`include "busCheck_defines.svh"

interface msgPairIf import busCheckPkg::*; ();

  logic       pairValid;
  canMsg_t    request;
  canMsg_t    response;
  reqOrigin_t origin;

  modport source
  (
    output pairValid,
    output request,
    output response,
    output origin
  );

  modport sink
  (
    input pairValid,
    input request,
    input response,
    input origin
  );

endinterface

/* design/requestCapture.sv */
//****************************************
// holds the current request and emits one pair per respMsg
// response is always taken from the uplink data
// a request loaded on the respMsg edge is not part of that pair
//****************************************
`timescale 1ns/1ps
`include "busCheck_defines.svh"

module requestCapture import busCheckPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     reqMsg,
  input  logic     respMsg,
  input  logic     testTx,
  input  logic     oscTrim,
  input  logic     trimStart,
  input  canMsg_t  uplinkData,
  input  canMsg_t  downlinkData,
  msgPairIf.source pair
);

  canMsg_t    heldReq;
  reqOrigin_t heldOrigin;

  // request register, trim has top priority
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      heldReq    <= '0;
      heldOrigin <= originUplink;
    end
    else if (trimStart && oscTrim)
    begin
      heldReq    <= `TRIM_PATTERN;
      heldOrigin <= originTrim;
    end
    else if (reqMsg && testTx)
    begin
      heldReq    <= downlinkData;   // TX mode drives the bus from the host side
      heldOrigin <= originDownlink;
    end
    else if (reqMsg)
    begin
      heldReq    <= uplinkData;     // RX and default mode
      heldOrigin <= originUplink;
    end
  end

  // response capture and pair output
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      pair.pairValid <= 1'b0;
      pair.request   <= '0;
      pair.response  <= '0;
      pair.origin    <= originUplink;
    end
    else
    begin
      pair.pairValid <= respMsg;
      if (respMsg)
      begin
        pair.request  <= heldReq;     // value before this edge
        pair.origin   <= heldOrigin;
        pair.response <= uplinkData;
      end
    end
  end

endmodule

/* design/responseMatcher.sv */
//****************************************
// judges each pair and registers one verdict
// SDO data bytes are not compared, only the addressing
// verdictKind follows the pair bus, read it with verdictValid
//****************************************
`timescale 1ns/1ps
`include "busCheck_defines.svh"

module responseMatcher import busCheckPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  busId_t     busId,
  msgPairIf.sink     pair,
  output logic       verdictValid,
  output logic       verdictPass,
  output checkKind_t verdictKind
);

  cobId_t     reqCob;
  cobId_t     respCob;
  funcCode_t  reqFunc;
  funcCode_t  respFunc;
  logic [7:0] reqCmd;
  logic [7:0] respCmd;
  sdoIndex_t  reqIdx;
  sdoIndex_t  respIdx;
  logic [7:0] reqSub;
  logic [7:0] respSub;
  canMsg_t    trimExpect;
  logic       guardOk;
  logic       sdoOk;
  logic       trimOk;
  logic       echoOk;
  checkKind_t kind;
  logic       pass;

  // field split of both messages
  assign reqCob   = pair.request[`COB_MSB:`COB_LSB];
  assign respCob  = pair.response[`COB_MSB:`COB_LSB];
  assign reqFunc  = pair.request[`COB_MSB -: `FUNC_W];
  assign respFunc = pair.response[`COB_MSB -: `FUNC_W];
  assign reqCmd   = pair.request[`CMD_MSB:`CMD_LSB];
  assign respCmd  = pair.response[`CMD_MSB:`CMD_LSB];
  assign reqIdx   = pair.request[`IDX_MSB:`IDX_LSB];
  assign respIdx  = pair.response[`IDX_MSB:`IDX_LSB];
  assign reqSub   = pair.request[`SUB_MSB:`SUB_LSB];
  assign respSub  = pair.response[`SUB_MSB:`SUB_LSB];

  // trim echo carries the bus number in place of one pattern byte
  always_comb
  begin
    trimExpect = `TRIM_PATTERN;
    trimExpect[`BUSID_MSB:`BUSID_LSB] = busId;
  end

  assign guardOk = (respCob == reqCob) && (respCmd == `GUARD_STATUS_OK);

  assign sdoOk = (respFunc == `FUNC_SDO_RESP)
              && (nodeId_t'(respCob) == nodeId_t'(reqCob))
              && (respCmd == `SDO_UPLOAD_RESP)
              && (respIdx == reqIdx)
              && (respSub == reqSub);

  assign trimOk = (pair.response == trimExpect);

  // loopback may change the low data byte only
  assign echoOk = (pair.response[`COB_MSB:`ECHO_LSB] == pair.request[`COB_MSB:`ECHO_LSB]);

  always_comb
  begin
    if (pair.origin == originTrim)
      kind = kindTrim;
    else if (reqFunc == `FUNC_NMT_GUARD)
      kind = kindNodeGuard;
    else if ((reqFunc == `FUNC_SDO_REQ) && (reqCmd == `SDO_UPLOAD_REQ))
      kind = kindSdoRead;
    else
      kind = kindEcho;   // anything else is treated as RX/TX loopback
  end

  always_comb
  begin
    case (kind)
      kindNodeGuard: pass = guardOk;
      kindSdoRead:   pass = sdoOk;
      kindTrim:      pass = trimOk;
      default:       pass = echoOk;
    endcase
  end

  always_ff @(posedge clk)
  begin
    verdictKind <= kind;
    if (!rst)
    begin
      verdictValid <= 1'b0;
      verdictPass  <= 1'b0;
    end
    else
    begin
      verdictValid <= pair.pairValid;
      verdictPass  <= pair.pairValid && pass;   // low between verdicts
    end
  end

endmodule

/* design/verdictTally.sv */
//****************************************
// pass and fail counts of all verdicts
// each count stops at its maximum value
//****************************************
`timescale 1ns/1ps
`include "busCheck_defines.svh"

module verdictTally import busCheckPkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   verdictValid,
  input  logic   verdictPass,
  output tally_t passCount,
  output tally_t failCount
);

  localparam tally_t tallyMax = {`TALLY_W{1'b1}};

  // add one unless already saturated
  function automatic tally_t satInc(input tally_t count);
    if (count == tallyMax)
      return count;
    return count + 1'b1;
  endfunction

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      passCount <= '0;
      failCount <= '0;
    end
    else if (verdictValid)
    begin
      if (verdictPass)
        passCount <= satInc(passCount);
      else
        failCount <= satInc(failCount);
    end
  end

endmodule

/* design/busActivityChecker.sv */
//****************************************
// checker top, request/response pairs on a CANopen bus
// verdict 2 cycles after respMsg, counts 3 cycles after
// responses may come on back-to-back cycles
// testRx selects the same source as no mode at all
//****************************************
`timescale 1ns/1ps
`include "busCheck_defines.svh"

module busActivityChecker import busCheckPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  busId_t     busId,
  input  logic       reqMsg,
  input  logic       respMsg,
  input  logic       testRx,        // RX mode, served by the default uplink source
  input  logic       testTx,
  input  logic       oscTrim,
  input  logic       trimStart,
  input  canMsg_t    uplinkData,
  input  canMsg_t    downlinkData,
  output logic       checkValid,
  output logic       checkPass,
  output checkKind_t checkKind,
  output tally_t     passCount,
  output tally_t     failCount
);

  msgPairIf pairBus();

  requestCapture uCapture
  (
    .clk          (clk),
    .rst          (rst),
    .reqMsg       (reqMsg),
    .respMsg      (respMsg),
    .testTx       (testTx),
    .oscTrim      (oscTrim),
    .trimStart    (trimStart),
    .uplinkData   (uplinkData),
    .downlinkData (downlinkData),
    .pair         (pairBus.source)
  );

  responseMatcher uMatcher
  (
    .clk          (clk),
    .rst          (rst),
    .busId        (busId),
    .pair         (pairBus.sink),
    .verdictValid (checkValid),
    .verdictPass  (checkPass),
    .verdictKind  (checkKind)
  );

  // counts follow the registered verdict by one cycle
  verdictTally uTally
  (
    .clk          (clk),
    .rst          (rst),
    .verdictValid (checkValid),
    .verdictPass  (checkPass),
    .passCount    (passCount),
    .failCount    (failCount)
  );

endmodule

/* verif/busActivityChecker_assertions.sv */
//****************************************
// protocol assertions bound into the checker top
// verdict latency is fixed at 2 cycles
// assertErrors holds the number of failed assertions
//****************************************
`timescale 1ns/1ps
`include "busCheck_defines.svh"

module busActivityChecker_assertions import busCheckPkg::*;
(
  input logic   clk,
  input logic   rst,
  input logic   respMsg,
  input logic   checkValid,
  input logic   checkPass,
  input tally_t passCount,
  input tally_t failCount
);

  int assertErrors = 0;

  // every response gives a verdict two edges later
  verdictFollows: assert property (@(posedge clk) disable iff (!rst)
    respMsg |-> ##2 checkValid)
    else
    begin
      assertErrors++;
      $error("checkValid missing 2 cycles after respMsg");
    end

  // and no verdict without one
  verdictPulse: assert property (@(posedge clk) disable iff (!rst)
    checkValid |-> $past(respMsg, 2))
    else
    begin
      assertErrors++;
      $error("checkValid without a response 2 cycles before");
    end

  passMonotonic: assert property (@(posedge clk) disable iff (!rst)
    passCount >= $past(passCount))
    else
    begin
      assertErrors++;
      $error("passCount decreased");
    end

  failMonotonic: assert property (@(posedge clk) disable iff (!rst)
    failCount >= $past(failCount))
    else
    begin
      assertErrors++;
      $error("failCount decreased");
    end

  // outputs clear one edge after reset is sampled
  resetClears: assert property (@(posedge clk)
    !rst |=> (!checkValid && !checkPass && passCount == '0 && failCount == '0))
    else
    begin
      assertErrors++;
      $error("outputs not cleared by reset");
    end

endmodule

bind busActivityChecker busActivityChecker_assertions uAssert
(
  .clk        (clk),
  .rst        (rst),
  .respMsg    (respMsg),
  .checkValid (checkValid),
  .checkPass  (checkPass),
  .passCount  (passCount),
  .failCount  (failCount)
);

/* verif/busActivityChecker_tb.sv */
//****************************************
// testbench for the bus-activity checker
// inputs change and outputs are read on the falling edge
// busId only changes at a transaction start, after an idle cycle
//****************************************
`timescale 1ns/1ps
`include "busCheck_defines.svh"

module busActivityChecker_tb import busCheckPkg::*; ();

  localparam int clkPeriod = 8;
  localparam int resetCycles = 10;
  localparam int numTrans = 400;
  localparam int maxTransCycles = 7;   // request, 3 gap, 2 responses, idle
  localparam int drainCycles = 4;

  typedef struct packed
  {
    logic       valid;
    logic       pass;
    checkKind_t kind;
  } verdict_t;

  logic       clk;
  logic       rst;
  busId_t     busId;
  logic       reqMsg;
  logic       respMsg;
  logic       testRx;
  logic       testTx;
  logic       oscTrim;
  logic       trimStart;
  canMsg_t    uplinkData;
  canMsg_t    downlinkData;
  logic       checkValid;
  logic       checkPass;
  checkKind_t checkKind;
  tally_t     passCount;
  tally_t     failCount;

  logic [31:0] lfsrState;
  logic        rxMode;
  logic        txMode;
  logic        trimMode;
  busId_t      busSel;
  canMsg_t     modelReq;       // request the DUT holds
  reqOrigin_t  modelOrigin;
  tally_t      modelPass;
  tally_t      modelFail;
  verdict_t    pending[$];     // verdicts due 2 cycles after the response cycle
  int          kindErrors;
  int          bitErrors;
  int          tallyErrors;

  busActivityChecker dut
  (
    .clk          (clk),
    .rst          (rst),
    .busId        (busId),
    .reqMsg       (reqMsg),
    .respMsg      (respMsg),
    .testRx       (testRx),
    .testTx       (testTx),
    .oscTrim      (oscTrim),
    .trimStart    (trimStart),
    .uplinkData   (uplinkData),
    .downlinkData (downlinkData),
    .checkValid   (checkValid),
    .checkPass    (checkPass),
    .checkKind    (checkKind),
    .passCount    (passCount),
    .failCount    (failCount)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(clkPeriod / 2) clk = ~clk;
  end

  // Galois form, taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h80200003;
    return s >> 1;
  endfunction

  function canMsg_t drawBits(input int n);
    canMsg_t val;
    int      i;
    val = '0;
    for (i = 0; i < n; i++)
    begin
      lfsrState = lfsrStep(lfsrState);
      val[i] = lfsrState[0];
    end
    return val;
  endfunction

  function logic drawBit();
    lfsrState = lfsrStep(lfsrState);
    return lfsrState[0];
  endfunction

  function canMsg_t nonzeroBits(input int n);
    canMsg_t val;
    val = drawBits(n);
    if (val == '0)
      val = 1;
    return val;
  endfunction

  // model of the classification rules
  function automatic checkKind_t expectedKind(input reqOrigin_t origin, input canMsg_t req);
    if (origin == originTrim)
      return kindTrim;
    if (req[75:72] == `FUNC_NMT_GUARD)
      return kindNodeGuard;
    if (req[75:72] == `FUNC_SDO_REQ && req[63:56] == `SDO_UPLOAD_REQ)
      return kindSdoRead;
    return kindEcho;
  endfunction

  function automatic logic expectedPass(input checkKind_t kind, input canMsg_t req,
                                        input canMsg_t resp, input busId_t bus);
    canMsg_t trimWord;
    trimWord = `TRIM_PATTERN;
    trimWord[31:24] = bus;
    case (kind)
      kindNodeGuard: return resp[75:64] == req[75:64] && resp[63:56] == `GUARD_STATUS_OK;
      kindSdoRead:   return resp[75:72] == `FUNC_SDO_RESP && resp[71:64] == req[71:64]
                         && resp[63:56] == `SDO_UPLOAD_RESP && resp[55:32] == req[55:32];
      kindTrim:      return resp == trimWord;
      default:       return resp[75:8] == req[75:8];   // low data byte is free
    endcase
  endfunction

  task automatic compareKind(input string name, input checkKind_t expected,
                             input checkKind_t actual);
    if (actual !== expected)
    begin
      kindErrors++;
      $display("FAIL %0t %s expected %s actual %0d", $time, name, expected.name(), actual);
    end
  endtask

  task automatic compareBit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      bitErrors++;
      $display("FAIL %0t %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  task automatic compareTally(input string name, input tally_t expected, input tally_t actual);
    if (actual !== expected)
    begin
      tallyErrors++;
      $display("FAIL %0t %s expected %0d actual %0d", $time, name, expected, actual);
    end
  endtask

  // counts lag the verdict by a cycle so they are compared before it is added
  task automatic checkOutputs();
    verdict_t due;
    compareTally("passCount", modelPass, passCount);
    compareTally("failCount", modelFail, failCount);
    due = pending.pop_front();
    compareBit("checkValid", due.valid, checkValid);
    compareBit("checkPass", due.valid && due.pass, checkPass);
    if (due.valid)
    begin
      compareKind("checkKind", due.kind, checkKind);
      if (due.pass && modelPass != '1)
        modelPass++;
      else if (!due.pass && modelFail != '1)
        modelFail++;
    end
  endtask

  task automatic runCycle(input logic req, input logic resp, input logic trim,
                          input canMsg_t up, input canMsg_t down);
    verdict_t next;
    @(negedge clk);
    checkOutputs();
    testRx = rxMode;
    testTx = txMode;
    oscTrim = trimMode;
    busId = busSel;
    reqMsg = req;
    respMsg = resp;
    trimStart = trim;
    uplinkData = up;
    downlinkData = down;
    next = '0;
    if (resp)
    begin
      next.valid = 1'b1;
      next.kind = expectedKind(modelOrigin, modelReq);   // held before this edge
      next.pass = expectedPass(next.kind, modelReq, up, busSel);
    end
    pending.push_back(next);
    if (trim && trimMode)
    begin
      modelReq = `TRIM_PATTERN;
      modelOrigin = originTrim;
    end
    else if (req)
    begin
      modelReq = txMode ? down : up;
      modelOrigin = txMode ? originDownlink : originUplink;
    end
  endtask

  function canMsg_t makeRequest(input checkKind_t want);
    canMsg_t word;
    word = drawBits(`MSG_W);
    if (want == kindNodeGuard)
      word[75:72] = `FUNC_NMT_GUARD;
    else if (want == kindSdoRead)
    begin
      word[75:72] = `FUNC_SDO_REQ;
      word[63:56] = `SDO_UPLOAD_REQ;
    end
    else if (word[75:72] == 4'h6 || word[75:72] == 4'h7)
      word[75] = 1'b1;   // keep plain traffic out of guard and SDO codes
    return word;
  endfunction

  // passing response, with one field broken when corrupt is set
  function canMsg_t makeResponse(input checkKind_t want, input canMsg_t req, input logic corrupt);
    canMsg_t    word;
    canMsg_t    flip;
    logic [1:0] field;
    int         pos;
    word = drawBits(`MSG_W);
    field = 2'(drawBits(2));
    pos = int'(drawBits(7));
    flip = '0;
    case (want)
      kindNodeGuard:
      begin
        word[75:64] = req[75:64];
        word[63:56] = `GUARD_STATUS_OK;
        if (field[0])
          flip[75:64] = 12'(nonzeroBits(12));
        else
          flip[63:56] = 8'(nonzeroBits(8));
      end
      kindSdoRead:
      begin
        word[75:72] = `FUNC_SDO_RESP;
        word[71:64] = req[71:64];
        word[63:56] = `SDO_UPLOAD_RESP;
        word[55:32] = req[55:32];   // data bytes stay random
        case (field)
          2'd0: flip[75:72] = 4'(nonzeroBits(4));
          2'd1: flip[71:64] = 8'(nonzeroBits(8));
          2'd2: flip[63:56] = 8'(nonzeroBits(8));
          default: flip[55:32] = 24'(nonzeroBits(24));
        endcase
      end
      kindTrim:
      begin
        word = `TRIM_PATTERN;
        word[31:24] = busSel;
        flip[pos % `MSG_W] = 1'b1;
      end
      default:
      begin
        word[75:8] = req[75:8];
        flip[8 + pos % 68] = 1'b1;
      end
    endcase
    return corrupt ? (word ^ flip) : word;
  endfunction

  task automatic runTransaction();
    checkKind_t want;
    canMsg_t    reqWord;
    canMsg_t    other;
    logic       reqBit;
    logic       trimBit;
    int         gap;
    want = checkKind_t'(drawBits(2));
    rxMode = drawBit();
    txMode = drawBit();
    busSel = busId_t'(drawBits(8));
    trimMode = (want == kindTrim) ? 1'b1 : drawBit();
    reqWord = makeRequest(want);
    other = drawBits(`MSG_W);
    reqBit = (want == kindTrim) ? drawBit() : 1'b1;   // trim outranks reqMsg
    trimBit = (want == kindTrim) ? 1'b1 : (!trimMode && drawBit());
    if (txMode)
      runCycle(reqBit, 1'b0, trimBit, other, reqWord);
    else
      runCycle(reqBit, 1'b0, trimBit, reqWord, other);
    gap = int'(drawBits(2));
    repeat (gap)
      runCycle(1'b0, 1'b0, 1'b0, drawBits(`MSG_W), drawBits(`MSG_W));
    runCycle(1'b0, 1'b1, 1'b0, makeResponse(want, reqWord, drawBit()), drawBits(`MSG_W));
    if (drawBits(2) == 0)
      runCycle(1'b0, 1'b1, 1'b0, makeResponse(want, reqWord, drawBit()), drawBits(`MSG_W));
    runCycle(1'b0, 1'b0, 1'b0, drawBits(`MSG_W), drawBits(`MSG_W));
  endtask

  initial
  begin
    lfsrState = 32'd38;
    rst = 1'b0;
    busId = '0;
    reqMsg = 1'b0;
    respMsg = 1'b0;
    testRx = 1'b0;
    testTx = 1'b0;
    oscTrim = 1'b0;
    trimStart = 1'b0;
    uplinkData = '0;
    downlinkData = '0;
    rxMode = 1'b0;
    txMode = 1'b0;
    trimMode = 1'b0;
    busSel = '0;
    modelReq = '0;
    modelOrigin = originUplink;
    modelPass = '0;
    modelFail = '0;
    kindErrors = 0;
    bitErrors = 0;
    tallyErrors = 0;
    pending.push_back('0);   // nothing due in the first two cycles after reset
    pending.push_back('0);
    repeat (resetCycles) @(negedge clk);
    rst = 1'b1;
    repeat (numTrans)
      runTransaction();
    repeat (drainCycles)
      runCycle(1'b0, 1'b0, 1'b0, '0, '0);
    $display("error counts: kind %0d, valid/pass %0d, tally %0d, assertion %0d %s",
             kindErrors, bitErrors, tallyErrors, dut.uAssert.assertErrors,
             $sformatf("(pass %0d, fail %0d seen)", modelPass, modelFail));
    if (kindErrors + bitErrors + tallyErrors + dut.uAssert.assertErrors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  // watchdog
  initial
  begin
    #((resetCycles + numTrans * maxTransCycles + drainCycles + 20) * clkPeriod);
    $display("timeout: stimulus did not complete in the expected time");
    $display("Checks failed");
    $finish;
  end

endmodule

/* sim.f */
+incdir+design
design/busCheckPkg.sv
design/msgPairIf.sv
design/requestCapture.sv
design/responseMatcher.sv
design/verdictTally.sv
design/busActivityChecker.sv
verif/busActivityChecker_assertions.sv
verif/busActivityChecker_tb.sv
